// ==== compile.f ====
source/pipeDefsPkg.sv
source/hazardCtrlPkg.sv
source/stageTracker.sv
source/pipelineControl.sv
source/forwardSelect.sv
source/hazardTop.sv
verif/hazardTb.sv

// ==== run.sh ====
#!/bin/sh
# build the hazard control testbench with Verilator and run it
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module hazardTb \
    -f compile.f -o hazardSim &&
./obj_dir/hazardSim > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== source/forwardSelect.sv ====
/*
 * forwarding select: picks the newest ready producer
 * for the rs and rt operands at D and at E
 */

`timescale 1ns/1ps

module forwardSelect
    import pipeDefsPkg::*;
    import hazardCtrlPkg::*;
(
    // reads at D
    input  logic    useRsD,
    input  logic    useRtD,
    input  regAddrT addrRsD,
    input  regAddrT addrRtD,
    // reads at E
    input  logic    useRsE,
    input  logic    useRtE,
    input  regAddrT addrRsE,
    input  regAddrT addrRtE,
    // writes in flight
    input  logic    regWEnE,
    input  logic    regWEnM,
    input  logic    regWEnW,
    input  regAddrT regWAddrE,
    input  regAddrT regWAddrM,
    input  regAddrT regWAddrW,
    input  tCountT  tNewE,
    input  tCountT  tNewM,
    input  tCountT  tNewW,
    // selects
    output fwdSelT  fwdRsD,
    output fwdSelT  fwdRtD,
    output fwdSelT  fwdRsE,
    output fwdSelT  fwdRtE
);

    // newest match decides; not ready means the controller stalls
    function automatic fwdSelT pickSrc(input logic inUse, input regAddrT addr,
                                       input logic lookE);
        fwdSelT sel;
        sel = fwdNone;
        if (inUse && (addr != zeroReg)) begin
            if (lookE && regWEnE && (regWAddrE == addr)) begin
                sel = (tNewE == '0) ? fwdE : fwdNone;
            end else if (regWEnM && (regWAddrM == addr)) begin
                sel = (tNewM == '0) ? fwdM : fwdNone;
            end else if (regWEnW && (regWAddrW == addr)) begin
                sel = (tNewW == '0) ? fwdW : fwdNone;
            end
        end
        return sel;
    endfunction

    always_comb begin
        // D operands see E, M and W
        fwdRsD = pickSrc(useRsD, addrRsD, 1'b1);
        fwdRtD = pickSrc(useRtD, addrRtD, 1'b1);
        // E operands only see later stages
        fwdRsE = pickSrc(useRsE, addrRsE, 1'b0);
        fwdRtE = pickSrc(useRtE, addrRtE, 1'b0);
    end

endmodule

// ==== source/hazardCtrlPkg.sv ====
/*
 * hazard control encodings: forwarding sources and
 * the priority patterns of the control word
 */

package hazardCtrlPkg;

    // operand source, newest producer wins
    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdE    = 2'd1,
        fwdM    = 2'd2,
        fwdW    = 2'd3
    } fwdSelT;

    // control word width
    localparam int ctrlVecW = 12;

    // bit order: enPC enMD enD enGRF | stall D E M W | clear D E M W
    // exl change: redirect PC, flush everything
    localparam logic [ctrlVecW-1:0] ctrlExl   = 12'b1001_0000_1111;
    // data memory busy: freeze D through W
    localparam logic [ctrlVecW-1:0] ctrlBusyD = 12'b0111_1111_0000;
    // hazard, MDU conflict or fetch busy: hold D, bubble into E
    localparam logic [ctrlVecW-1:0] ctrlHold  = 12'b0111_1000_0100;
    // free running
    localparam logic [ctrlVecW-1:0] ctrlRun   = 12'b1111_0000_0000;

endpackage

// ==== source/hazardTop.sv ====
/*
 * hazard and stall control top: stage tracker,
 * controller and forwarding select
 */

`timescale 1ns/1ps

module hazardTop
    import pipeDefsPkg::*;
    import hazardCtrlPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    // D stage
    input  logic    dValid,
    input  iFuncT   iFuncD,
    input  logic    useRsD,
    input  logic    useRtD,
    input  regAddrT addrRsD,
    input  regAddrT addrRtD,
    input  tCountT  tUseRsD,
    input  tCountT  tUseRtD,
    input  logic    regWEnD,
    input  regAddrT regWAddrD,
    input  tCountT  tNewD,
    // status
    input  logic    busyI,
    input  logic    busyD,
    input  logic    busyMD,
    input  logic    exl,
    // control
    output logic    enPC,
    output logic    enMD,
    output logic    enD,
    output logic    enGRF,
    output logic    stallD,
    output logic    clearD,
    output logic    stallE,
    output logic    clearE,
    output logic    stallM,
    output logic    clearM,
    output logic    stallW,
    output logic    clearW,
    // forwarding
    output fwdSelT  fwdRsD,
    output fwdSelT  fwdRtD,
    output fwdSelT  fwdRsE,
    output fwdSelT  fwdRtE
);

    // write records
    logic    regWEnE;
    logic    regWEnM;
    logic    regWEnW;
    regAddrT regWAddrE;
    regAddrT regWAddrM;
    regAddrT regWAddrW;
    tCountT  tNewE;
    tCountT  tNewM;
    tCountT  tNewW;
    // E reads
    logic    useRsE;
    logic    useRtE;
    regAddrT addrRsE;
    regAddrT addrRtE;

    stageTracker i_stageTracker (
        .clk       (clk),
        .arstN     (arstN),
        .dValid    (dValid),
        .regWEnD   (regWEnD),
        .regWAddrD (regWAddrD),
        .tNewD     (tNewD),
        .useRsD    (useRsD),
        .useRtD    (useRtD),
        .addrRsD   (addrRsD),
        .addrRtD   (addrRtD),
        .stallE    (stallE),
        .clearE    (clearE),
        .stallM    (stallM),
        .clearM    (clearM),
        .stallW    (stallW),
        .clearW    (clearW),
        .regWEnE   (regWEnE),
        .regWEnM   (regWEnM),
        .regWEnW   (regWEnW),
        .regWAddrE (regWAddrE),
        .regWAddrM (regWAddrM),
        .regWAddrW (regWAddrW),
        .tNewE     (tNewE),
        .tNewM     (tNewM),
        .tNewW     (tNewW),
        .useRsE    (useRsE),
        .useRtE    (useRtE),
        .addrRsE   (addrRsE),
        .addrRtE   (addrRtE)
    );

    // W never stalls D, so only E and M go to the controller
    pipelineControl i_pipelineControl (
        .iFuncD    (iFuncD),
        .dValid    (dValid),
        .useRsD    (useRsD),
        .useRtD    (useRtD),
        .addrRsD   (addrRsD),
        .addrRtD   (addrRtD),
        .tUseRsD   (tUseRsD),
        .tUseRtD   (tUseRtD),
        .regWEnE   (regWEnE),
        .regWAddrE (regWAddrE),
        .tNewE     (tNewE),
        .regWEnM   (regWEnM),
        .regWAddrM (regWAddrM),
        .tNewM     (tNewM),
        .busyI     (busyI),
        .busyD     (busyD),
        .busyMD    (busyMD),
        .exl       (exl),
        .enPC      (enPC),
        .enMD      (enMD),
        .enD       (enD),
        .enGRF     (enGRF),
        .stallD    (stallD),
        .stallE    (stallE),
        .stallM    (stallM),
        .stallW    (stallW),
        .clearD    (clearD),
        .clearE    (clearE),
        .clearM    (clearM),
        .clearW    (clearW)
    );

    forwardSelect i_forwardSelect (
        .useRsD    (useRsD),
        .useRtD    (useRtD),
        .addrRsD   (addrRsD),
        .addrRtD   (addrRtD),
        .useRsE    (useRsE),
        .useRtE    (useRtE),
        .addrRsE   (addrRsE),
        .addrRtE   (addrRtE),
        .regWEnE   (regWEnE),
        .regWEnM   (regWEnM),
        .regWEnW   (regWEnW),
        .regWAddrE (regWAddrE),
        .regWAddrM (regWAddrM),
        .regWAddrW (regWAddrW),
        .tNewE     (tNewE),
        .tNewM     (tNewM),
        .tNewW     (tNewW),
        .fwdRsD    (fwdRsD),
        .fwdRtD    (fwdRtD),
        .fwdRsE    (fwdRsE),
        .fwdRtE    (fwdRtE)
    );

endmodule

// ==== source/pipeDefsPkg.sv ====
/*
 * pipeline definitions shared by the hazard control blocks:
 * register addresses, Tnew/Tuse counts and instruction classes
 */

package pipeDefsPkg;

    // register address, 32 GPRs
    localparam int regAddrW = 5;

    // Tnew / Tuse count, 0 to 3 cycles
    localparam int tnewW = 2;

    typedef logic [regAddrW-1:0] regAddrT;
    typedef logic [tnewW-1:0] tCountT;

    // r0 reads as zero and never creates a dependency
    localparam regAddrT zeroReg = '0;

    // instruction class at D, as seen by the controller
    typedef enum logic [2:0] {
        // register-register and immediate arithmetic
        iAlu    = 3'd0,
        // memory read, result late in M
        iLoad   = 3'd1,
        // memory write, no register result
        iStore  = 3'd2,
        // branches and jumps resolved at D
        iBranch = 3'd3,
        // multiply / divide, needs the MDU
        iMd     = 3'd4,
        // anything else
        iOther  = 3'd5
    } iFuncT;

endpackage

// ==== source/pipelineControl.sv ====
/*
 * pipeline controller: data hazard and MDU conflict detection,
 * prioritized stall / clear / enable generation
 */

`timescale 1ns/1ps

module pipelineControl
    import pipeDefsPkg::*;
    import hazardCtrlPkg::*;
(
    // instruction at D
    input  iFuncT   iFuncD,
    input  logic    dValid,
    input  logic    useRsD,
    input  logic    useRtD,
    input  regAddrT addrRsD,
    input  regAddrT addrRtD,
    input  tCountT  tUseRsD,
    input  tCountT  tUseRtD,
    // writes in flight
    input  logic    regWEnE,
    input  regAddrT regWAddrE,
    input  tCountT  tNewE,
    input  logic    regWEnM,
    input  regAddrT regWAddrM,
    input  tCountT  tNewM,
    // status
    input  logic    busyI,
    input  logic    busyD,
    input  logic    busyMD,
    input  logic    exl,
    // enables
    output logic    enPC,
    output logic    enMD,
    output logic    enD,
    output logic    enGRF,
    // stalls
    output logic    stallD,
    output logic    stallE,
    output logic    stallM,
    output logic    stallW,
    // clears
    output logic    clearD,
    output logic    clearE,
    output logic    clearM,
    output logic    clearW
);

    logic waitRs;
    logic waitRt;
    logic waitReg;
    logic waitMD;
    logic [ctrlVecW-1:0] ctrlVec;

    // rs needed before E or M can deliver it
    assign waitRs = useRsD && (addrRsD != zeroReg) && (
        (regWEnE && (regWAddrE == addrRsD) && (tNewE > tUseRsD)) ||
        (regWEnM && (regWAddrM == addrRsD) && (tNewM > tUseRsD)));

    // same for rt
    assign waitRt = useRtD && (addrRtD != zeroReg) && (
        (regWEnE && (regWAddrE == addrRtD) && (tNewE > tUseRtD)) ||
        (regWEnM && (regWAddrM == addrRtD) && (tNewM > tUseRtD)));

    // a bubble at D never waits
    assign waitReg = dValid & (waitRs | waitRt);

    // md op while the MDU is still busy
    assign waitMD = dValid & busyMD & (iFuncD == iMd);

    // priority: exl, then busyD, then the D-side holds
    always_comb begin
        if (exl) begin
            ctrlVec = ctrlExl;
        end else if (busyD) begin
            ctrlVec = ctrlBusyD;
        end else if (waitReg | waitMD | busyI) begin
            ctrlVec = ctrlHold;
        end else begin
            ctrlVec = ctrlRun;
        end
    end

    assign {enPC, enMD, enD, enGRF,
            stallD, stallE, stallM, stallW,
            clearD, clearE, clearM, clearW} = ctrlVec;

    // a stage is either held or flushed, never both
    always_comb begin
        stallClearExcl: assert ((ctrlVec[7:4] & ctrlVec[3:0]) == 4'b0000)
            else $error("stall and clear both set on one stage");
    end

endmodule

// ==== source/stageTracker.sv ====
/*
 * stage tracker: D/E, E/M and M/W records of register writes
 * and E-stage reads, with saturating Tnew countdown
 */

`timescale 1ns/1ps

module stageTracker
    import pipeDefsPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    // D stage
    input  logic    dValid,
    input  logic    regWEnD,
    input  regAddrT regWAddrD,
    input  tCountT  tNewD,
    input  logic    useRsD,
    input  logic    useRtD,
    input  regAddrT addrRsD,
    input  regAddrT addrRtD,
    // from the controller
    input  logic    stallE,
    input  logic    clearE,
    input  logic    stallM,
    input  logic    clearM,
    input  logic    stallW,
    input  logic    clearW,
    // write records
    output logic    regWEnE,
    output logic    regWEnM,
    output logic    regWEnW,
    output regAddrT regWAddrE,
    output regAddrT regWAddrM,
    output regAddrT regWAddrW,
    output tCountT  tNewE,
    output tCountT  tNewM,
    output tCountT  tNewW,
    // E-stage reads
    output logic    useRsE,
    output logic    useRtE,
    output regAddrT addrRsE,
    output regAddrT addrRtE
);

    // one cycle closer to ready, floor at 0
    function automatic tCountT satDec(input tCountT t);
        return (t == '0) ? '0 : t - 1'b1;
    endfunction

    // valid flags
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWEnE <= 1'b0;
            useRsE  <= 1'b0;
            useRtE  <= 1'b0;
            regWEnM <= 1'b0;
            regWEnW <= 1'b0;
        end else begin
            // clear beats stall
            if (clearE) begin
                regWEnE <= 1'b0;
                useRsE  <= 1'b0;
                useRtE  <= 1'b0;
            end else if (!stallE) begin
                // bubbles and r0 writes enter E without a write
                regWEnE <= dValid & regWEnD & (regWAddrD != zeroReg);
                useRsE  <= dValid & useRsD;
                useRtE  <= dValid & useRtD;
            end
            if (clearM) begin
                regWEnM <= 1'b0;
            end else if (!stallM) begin
                regWEnM <= regWEnE;
            end
            if (clearW) begin
                regWEnW <= 1'b0;
            end else if (!stallW) begin
                regWEnW <= regWEnM;
            end
        end
    end

    // addresses and Tnew, only meaningful under the flags
    always_ff @(posedge clk) begin
        if (!stallE) begin
            regWAddrE <= regWAddrD;
            tNewE     <= satDec(tNewD);
            addrRsE   <= addrRsD;
            addrRtE   <= addrRtD;
        end else begin
            // held stage still counts down
            tNewE <= satDec(tNewE);
        end
        if (!stallM) begin
            regWAddrM <= regWAddrE;
            tNewM     <= satDec(tNewE);
        end else begin
            tNewM <= satDec(tNewM);
        end
        if (!stallW) begin
            regWAddrW <= regWAddrM;
            tNewW     <= satDec(tNewM);
        end else begin
            tNewW <= satDec(tNewW);
        end
    end

    // flushed stage carries no write afterwards
    clearKillsE: assert property (@(posedge clk) disable iff (!arstN)
        clearE |=> !regWEnE)
        else $error("E write survived a clear");
    clearKillsM: assert property (@(posedge clk) disable iff (!arstN)
        clearM |=> !regWEnM)
        else $error("M write survived a clear");
    clearKillsW: assert property (@(posedge clk) disable iff (!arstN)
        clearW |=> !regWEnW)
        else $error("W write survived a clear");

    // r0 writes filtered at entry, so none downstream
    noZeroWrite: assert property (@(posedge clk) disable iff (!arstN)
        (regWEnE -> regWAddrE != zeroReg) && (regWEnM -> regWAddrM != zeroReg) &&
        (regWEnW -> regWAddrW != zeroReg))
        else $error("write record targets r0");

endmodule

// ==== verif/hazardTb.sv ====
/*
 * hazard control testbench: directed tests for priority,
 * load-use stalls, forwarding selects and record freezing
 */

`timescale 1ns/1ps

module hazardTb
    import pipeDefsPkg::*;
    import hazardCtrlPkg::*;
;

    localparam int halfPeriod   = 2;
    localparam int resetCycles  = 5;
    localparam int stallTimeout = 20;

    // expected control words
    // bit order: enPC enMD enD enGRF | stall D E M W | clear D E M W
    localparam logic [ctrlVecW-1:0] expRun   = 12'b1111_0000_0000;
    localparam logic [ctrlVecW-1:0] expHold  = 12'b0111_1000_0100;
    localparam logic [ctrlVecW-1:0] expBusyD = 12'b0111_1111_0000;
    localparam logic [ctrlVecW-1:0] expExl   = 12'b1001_0000_1111;

    logic    clk;
    logic    arstN;
    logic    dValid;
    iFuncT   iFuncD;
    logic    useRsD;
    logic    useRtD;
    regAddrT addrRsD;
    regAddrT addrRtD;
    tCountT  tUseRsD;
    tCountT  tUseRtD;
    logic    regWEnD;
    regAddrT regWAddrD;
    tCountT  tNewD;
    logic    busyI;
    logic    busyD;
    logic    busyMD;
    logic    exl;
    logic    enPC;
    logic    enMD;
    logic    enD;
    logic    enGRF;
    logic    stallD;
    logic    clearD;
    logic    stallE;
    logic    clearE;
    logic    stallM;
    logic    clearM;
    logic    stallW;
    logic    clearW;
    fwdSelT  fwdRsD;
    fwdSelT  fwdRtD;
    fwdSelT  fwdRsE;
    fwdSelT  fwdRtE;

    integer seed = 15221;
    int     errCount = 0;
    int     checksDone = 0;
    int     testCount = 0;

    hazardTop i_hazardTop (
        .clk(clk), .arstN(arstN), .dValid(dValid), .iFuncD(iFuncD),
        .useRsD(useRsD), .useRtD(useRtD), .addrRsD(addrRsD), .addrRtD(addrRtD),
        .tUseRsD(tUseRsD), .tUseRtD(tUseRtD), .regWEnD(regWEnD),
        .regWAddrD(regWAddrD), .tNewD(tNewD), .busyI(busyI), .busyD(busyD),
        .busyMD(busyMD), .exl(exl), .enPC(enPC), .enMD(enMD), .enD(enD),
        .enGRF(enGRF), .stallD(stallD), .clearD(clearD), .stallE(stallE),
        .clearE(clearE), .stallM(stallM), .clearM(clearM), .stallW(stallW),
        .clearW(clearW), .fwdRsD(fwdRsD), .fwdRtD(fwdRtD), .fwdRsE(fwdRsE),
        .fwdRtE(fwdRtE)
    );

    // 4 ns clock
    always #(halfPeriod) clk = ~clk;

    // nonzero register, 1 to 31
    function automatic regAddrT randomReg();
        return regAddrT'(($unsigned($random(seed)) % 31) + 1);
    endfunction

    // D stage contents, called on the falling edge
    task automatic driveD(input logic valid, input iFuncT func,
                          input logic uRs, input regAddrT rs, input tCountT tuRs,
                          input logic uRt, input regAddrT rt, input tCountT tuRt,
                          input logic wEn, input regAddrT wAddr, input tCountT tNew);
        dValid    = valid;
        iFuncD    = func;
        useRsD    = uRs;
        addrRsD   = rs;
        tUseRsD   = tuRs;
        useRtD    = uRt;
        addrRtD   = rt;
        tUseRtD   = tuRt;
        regWEnD   = wEn;
        regWAddrD = wAddr;
        tNewD     = tNew;
    endtask

    task automatic issueBubble();
        driveD(1'b0, iAlu, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    // producer with no source operands
    task automatic issueWrite(input iFuncT func, input regAddrT wAddr, input tCountT tNew);
        driveD(1'b1, func, 1'b0, '0, '0, 1'b0, '0, '0, 1'b1, wAddr, tNew);
    endtask

    // alu consumer of rs only
    task automatic issueRead(input regAddrT rs, input tCountT tuRs);
        driveD(1'b1, iAlu, 1'b1, rs, tuRs, 1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    // status idle, then bubbles until E, M and W are empty
    task automatic drain(input int cycles);
        busyI  = 1'b0;
        busyD  = 1'b0;
        busyMD = 1'b0;
        exl    = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            issueBubble();
        end
    endtask

    task automatic checkCtrl(input string name, input logic [ctrlVecW-1:0] exp);
        logic [ctrlVecW-1:0] act;
        act = {enPC, enMD, enD, enGRF, stallD, stallE, stallM, stallW,
               clearD, clearE, clearM, clearW};
        checksDone++;
        if (act !== exp) begin
            $display("Error: %s control expected %b actual %b", name, exp, act);
            errCount++;
        end
    endtask

    task automatic checkFwd(input string name, input string what,
                            input fwdSelT exp, input fwdSelT act);
        checksDone++;
        if (act !== exp) begin
            $display("Error: %s %s expected %s actual %s", name, what, exp.name(), act.name());
            errCount++;
        end
    endtask

    task automatic checkStallCycles(input string name, input int exp, input int act);
        checksDone++;
        if (act != exp) begin
            $display("Error: %s stall cycles expected %0d actual %0d", name, exp, act);
            errCount++;
        end
    endtask

    // follower: D inputs stay put while stallD is high
    task automatic holdWhileStalled(input string name, output int cycles);
        cycles = 0;
        while (stallD && cycles < stallTimeout) begin
            checkCtrl(name, expHold);
            cycles++;
            @(negedge clk);
            #1;
        end
        if (stallD) begin
            $display("%s: stallD still high after %0d cycles", name, stallTimeout);
            errCount++;
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testCount++;
        if (errCount == errBefore) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errCount - errBefore);
        end
    endtask

    task automatic resetIdle();
        int errBefore;
        errBefore = errCount;
        #1;
        checkCtrl("resetIdle", expRun);
        checkFwd("resetIdle", "fwdRsD", fwdNone, fwdRsD);
        checkFwd("resetIdle", "fwdRtD", fwdNone, fwdRtD);
        checkFwd("resetIdle", "fwdRsE", fwdNone, fwdRsE);
        checkFwd("resetIdle", "fwdRtE", fwdNone, fwdRtE);
        finishTest("resetIdle", errBefore);
    endtask

    task automatic loadUse();
        regAddrT r;
        int      errBefore;
        int      stalls;
        errBefore = errCount;
        r = randomReg();
        drain(4);
        @(negedge clk);
        issueWrite(iLoad, r, 2'd2);
        #1;
        checkCtrl("loadUse", expRun);
        @(negedge clk);
        issueRead(r, 2'd0);
        #1;
        // load in E with Tnew 1 against Tuse 0
        holdWhileStalled("loadUse", stalls);
        checkStallCycles("loadUse", 1, stalls);
        checkCtrl("loadUse", expRun);
        checkFwd("loadUse", "fwdRsD", fwdM, fwdRsD);
        @(negedge clk);
        issueBubble();
        #1;
        // E was flushed, so M is a bubble and the load sits in W
        checkFwd("loadUse", "fwdRsE", fwdW, fwdRsE);
        finishTest("loadUse", errBefore);
    endtask

    task automatic aluChain();
        regAddrT r;
        int      errBefore;
        errBefore = errCount;
        r = randomReg();
        drain(4);
        @(negedge clk);
        issueWrite(iAlu, r, 2'd1);
        #1;
        checkCtrl("aluChain", expRun);
        @(negedge clk);
        issueRead(r, 2'd1);
        #1;
        checkCtrl("aluChain", expRun);
        checkFwd("aluChain", "fwdRsD", fwdE, fwdRsD);
        @(negedge clk);
        issueBubble();
        #1;
        checkFwd("aluChain", "fwdRsE", fwdM, fwdRsE);
        // r0 is never a dependency
        drain(4);
        @(negedge clk);
        issueWrite(iLoad, '0, 2'd2);
        @(negedge clk);
        driveD(1'b1, iAlu, 1'b1, '0, '0, 1'b1, '0, '0, 1'b0, '0, '0);
        #1;
        checkCtrl("aluChain", expRun);
        checkFwd("aluChain", "fwdRsD r0", fwdNone, fwdRsD);
        checkFwd("aluChain", "fwdRtD r0", fwdNone, fwdRtD);
        @(negedge clk);
        issueBubble();
        #1;
        checkFwd("aluChain", "fwdRsE r0", fwdNone, fwdRsE);
        checkFwd("aluChain", "fwdRtE r0", fwdNone, fwdRtE);
        finishTest("aluChain", errBefore);
    endtask

    task automatic busyFreeze();
        regAddrT r;
        int      errBefore;
        errBefore = errCount;
        r = randomReg();
        drain(4);
        @(negedge clk);
        issueWrite(iLoad, r, 2'd2);
        @(negedge clk);
        busyD = 1'b1;
        issueBubble();
        repeat (3) begin
            #1;
            checkCtrl("busyFreeze", expBusyD);
            @(negedge clk);
        end
        busyD = 1'b0;
        // load still in E, countdown reached 0 while frozen
        issueRead(r, 2'd0);
        #1;
        checkCtrl("busyFreeze", expRun);
        checkFwd("busyFreeze", "fwdRsD", fwdE, fwdRsD);
        @(negedge clk);
        issueBubble();
        #1;
        checkFwd("busyFreeze", "fwdRsE", fwdM, fwdRsE);
        finishTest("busyFreeze", errBefore);
    endtask

    task automatic mduConflict();
        int errBefore;
        errBefore = errCount;
        drain(4);
        @(negedge clk);
        busyMD = 1'b1;
        driveD(1'b1, iMd, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0, '0);
        #1;
        checkCtrl("mduConflict", expHold);
        // MDU frees up, md op held in D proceeds
        @(negedge clk);
        busyMD = 1'b0;
        #1;
        checkCtrl("mduConflict", expRun);
        @(negedge clk);
        busyMD = 1'b1;
        driveD(1'b1, iAlu, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0, '0);
        #1;
        checkCtrl("mduConflict", expRun);
        @(negedge clk);
        busyMD = 1'b0;
        issueBubble();
        finishTest("mduConflict", errBefore);
    endtask

    task automatic exlPriority();
        regAddrT r;
        regAddrT r2;
        int      errBefore;
        errBefore = errCount;
        r  = randomReg();
        // always differs from r
        r2 = regAddrT'((r % 31) + 1);
        drain(4);
        @(negedge clk);
        issueWrite(iAlu, r2, 2'd1);
        @(negedge clk);
        issueWrite(iLoad, r, 2'd2);
        @(negedge clk);
        // hazard on rs, busyD and exl all at once
        exl   = 1'b1;
        busyD = 1'b1;
        driveD(1'b1, iAlu, 1'b1, r, 2'd0, 1'b1, r2, 2'd0, 1'b0, '0, '0);
        #1;
        checkCtrl("exlPriority", expExl);
        @(negedge clk);
        exl   = 1'b0;
        busyD = 1'b0;
        #1;
        checkCtrl("exlPriority", expRun);
        checkFwd("exlPriority", "fwdRsD", fwdNone, fwdRsD);
        checkFwd("exlPriority", "fwdRtD", fwdNone, fwdRtD);
        checkFwd("exlPriority", "fwdRsE", fwdNone, fwdRsE);
        checkFwd("exlPriority", "fwdRtE", fwdNone, fwdRtE);
        finishTest("exlPriority", errBefore);
    endtask

    initial begin
        clk    = 1'b0;
        arstN  = 1'b0;
        busyI  = 1'b0;
        busyD  = 1'b0;
        busyMD = 1'b0;
        exl    = 1'b0;
        issueBubble();
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        resetIdle();
        loadUse();
        aluChain();
        busyFreeze();
        mduConflict();
        exlPriority();
        $display("tests %0d, checks %0d, errors %0d", testCount, checksDone, errCount);
        if (errCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
